/* src/ready_pkg.sv */
`default_nettype none

package ready_pkg;

	// ============================================================
	// Sizes
	// ============================================================

	// Physical registers tracked in each checkpoint row
	localparam int PREGS = 64;

	// Checkpoint slots, one row of the valid RAM each
	localparam int NCHECK = 8;

	// Width of the tag carried from command to response
	localparam int TAGW = 4;

	// Physical register number and checkpoint slot index
	typedef logic [$clog2(PREGS)-1:0] pregno_t;
	typedef logic [$clog2(NCHECK)-1:0] checkpt_ndx_t;

	// ============================================================
	// Command interface
	// ============================================================

	// Opcodes of the command strobe
	typedef enum logic [2:0] {
		OP_NOP          = 3'd0,
		OP_ISSUE        = 3'd1,
		OP_QUERY        = 3'd2,
		OP_CKPT_NEW     = 3'd3,
		OP_CKPT_RESTORE = 3'd4
	} ready_op_e;

	// One command, sampled whenever cmd_valid is high
	typedef struct packed {
		ready_op_e op;
		pregno_t dst;
		pregno_t src_a;
		pregno_t src_b;
		checkpt_ndx_t ckpt;
		logic [TAGW-1:0] tag;
	} ready_cmd_t;

	// A writeback lane marks one physical register as ready
	typedef struct packed {
		logic valid;
		pregno_t preg;
	} wb_lane_t;

	// ============================================================
	// Internal controls and response
	// ============================================================

	// Decoded controls for the RAM, the checkpoint stack and the result stage
	typedef struct packed {
		logic issue_we;
		pregno_t issue_preg;
		logic query_en;
		pregno_t rd_a;
		pregno_t rd_b;
		logic [TAGW-1:0] tag;
		logic ckpt_new;
		logic ckpt_restore;
		checkpt_ndx_t restore_ndx;
	} ram_ctl_t;

	// Response strobe payload
	// err is set when a checkpoint command was refused
	typedef struct packed {
		logic [TAGW-1:0] tag;
		logic rdy_a;
		logic rdy_b;
		logic err;
	} query_rsp_t;

endpackage

`default_nettype wire

/* src/ready_cmd_decode.sv */
`timescale 1ns/1ps
`default_nettype none

module ready_cmd_decode #(
	parameter int NWB = 2
) (
	input logic clka,
	input logic rst,
	input logic cmd_valid,
	input ready_pkg::ready_cmd_t cmd,
	input ready_pkg::wb_lane_t wb [NWB],
	output ready_pkg::ram_ctl_t ctl,
	output ready_pkg::wb_lane_t wb_q [NWB]
);

	// Next value of the control register
	ready_pkg::ram_ctl_t ctl_d;

	// ============================================================
	// Opcode decode
	// ============================================================

	// Every field defaults to zero so an idle cycle is a clean NOP
	// Only one opcode arrives per cycle, so at most one action bit is set
	always_comb begin
		ctl_d = '0;
		if (cmd_valid) begin
			// The tag rides along for queries and for refused checkpoint commands
			ctl_d.tag = cmd.tag;
			case (cmd.op)
				ready_pkg::OP_ISSUE: begin
					// Destination becomes not ready until a writeback sets it
					ctl_d.issue_we = 1'b1;
					ctl_d.issue_preg = cmd.dst;
				end
				ready_pkg::OP_QUERY: begin
					ctl_d.query_en = 1'b1;
					ctl_d.rd_a = cmd.src_a;
					ctl_d.rd_b = cmd.src_b;
				end
				ready_pkg::OP_CKPT_NEW: begin
					ctl_d.ckpt_new = 1'b1;
				end
				ready_pkg::OP_CKPT_RESTORE: begin
					// Target slot is checked against the depth in the controller
					ctl_d.ckpt_restore = 1'b1;
					ctl_d.restore_ndx = cmd.ckpt;
				end
				default: begin
					// NOP and unused encodings do nothing
				end
			endcase
		end
	end

	// ============================================================
	// Pipeline register
	// ============================================================

	// Commands and writeback lanes share one stage
	// This keeps a lane in the same RAM cycle as the command sent beside it
	always_ff @(posedge clka) begin
		if (rst) begin
			ctl <= '0;
			for (int i = 0; i < NWB; i++) begin
				wb_q[i] <= '0;
			end
		end else begin
			ctl <= ctl_d;
			for (int i = 0; i < NWB; i++) begin
				wb_q[i] <= wb[i];
			end
		end
	end

	// The RAM takes either a row copy or bit writes, never both from one command
	// Checked one cycle after the strobe, on the registered controls
	a_one_action: assert property (@(posedge clka) disable iff (rst)
		cmd_valid |=> $onehot0({ctl.issue_we, ctl.ckpt_new, ctl.ckpt_restore}))
	else
		$error("ready_cmd_decode: more than one action decoded from one command");

endmodule

`default_nettype wire

/* src/checkpoint_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module checkpoint_ctrl (
	input logic clka,
	input logic rst,
	input ready_pkg::ram_ctl_t ctl,
	output ready_pkg::checkpt_ndx_t cur_ndx,
	output logic copy_en,
	output ready_pkg::checkpt_ndx_t copy_dst,
	output logic ckpt_err
);

	// Highest slot the stack may reach
	localparam ready_pkg::checkpt_ndx_t TOP_NDX =
		ready_pkg::checkpt_ndx_t'(ready_pkg::NCHECK - 1);

	// The stack pointer is also the live row of the RAM
	ready_pkg::checkpt_ndx_t depth;

	// Refusal conditions
	logic full;
	logic fwd_restore;
	logic restore_ok;

	assign cur_ndx = depth;

	// ============================================================
	// Checkpoint requests
	// ============================================================

	// A new checkpoint needs a free slot above the current one
	assign full = (depth == TOP_NDX);

	// A restore can only go back down the stack, or stay in place
	assign fwd_restore = (ctl.restore_ndx > depth);

	// The copy writes the next slot up and happens in this same cycle
	assign copy_en = ctl.ckpt_new & ~full;
	assign copy_dst = depth + 1'b1;

	assign restore_ok = ctl.ckpt_restore & ~fwd_restore;

	// Combinational so the result stage registers it on the same edge as a query
	assign ckpt_err = (ctl.ckpt_new & full) | (ctl.ckpt_restore & fwd_restore);

	// ============================================================
	// Stack pointer
	// ============================================================

	// Refused commands leave the depth where it was
	always_ff @(posedge clka) begin
		if (rst) begin
			depth <= '0;
		end else if (copy_en) begin
			depth <= copy_dst;
		end else if (restore_ok) begin
			// Older rows still hold their snapshot, so only the pointer moves
			depth <= ctl.restore_ndx;
		end
	end

	// The live row must stay inside the RAM when NCHECK is not a power of two
	a_depth_range: assert property (@(posedge clka) disable iff (rst)
		depth <= TOP_NDX)
	else
		$error("checkpoint_ctrl: depth %0d beyond last slot", depth);

endmodule

`default_nettype wire

/* src/checkpoint_valid_ram.sv */
`timescale 1ns/1ps
`default_nettype none

module checkpoint_valid_ram #(
	parameter int NWB = 2
) (
	input logic clka,
	input logic rst,
	input ready_pkg::checkpt_ndx_t cur_ndx,
	input logic copy_en,
	input ready_pkg::checkpt_ndx_t copy_dst,
	input ready_pkg::ram_ctl_t ctl,
	input ready_pkg::wb_lane_t wb_q [NWB],
	output logic [1:0] rd_out
);

	// Port 0 is the issue clear and ports 1..NWB are the writeback lanes
	localparam int NWP = NWB + 1;

	// The last physical register always reads as valid like register 0
	localparam ready_pkg::pregno_t LAST_PREG =
		ready_pkg::pregno_t'(ready_pkg::PREGS - 1);

	// One row of valid bits per checkpoint slot
	logic [ready_pkg::PREGS-1:0] mem [ready_pkg::NCHECK];

	// Flattened write ports
	logic [NWP-1:0] wr_en;
	ready_pkg::pregno_t wr_preg [NWP];

	// Bit masks built from the ports, and the rows written back
	logic [ready_pkg::PREGS-1:0] set_mask;
	logic [ready_pkg::PREGS-1:0] clr_mask;
	logic [ready_pkg::PREGS-1:0] cur_row;
	logic [ready_pkg::PREGS-1:0] upd_row;
	logic [ready_pkg::PREGS-1:0] copy_row;

	// ============================================================
	// Write ports
	// ============================================================

	always_comb begin
		wr_en[0] = ctl.issue_we;
		wr_preg[0] = ctl.issue_preg;
		for (int i = 0; i < NWB; i++) begin
			wr_en[i+1] = wb_q[i].valid;
			wr_preg[i+1] = wb_q[i].preg;
		end
	end

	// Port 0 feeds the clear mask and every lane port feeds the set mask
	always_comb begin
		set_mask = '0;
		clr_mask = '0;
		if (wr_en[0]) begin
			clr_mask[wr_preg[0]] = 1'b1;
		end
		for (int p = 1; p < NWP; p++) begin
			if (wr_en[p]) begin
				set_mask[wr_preg[p]] = 1'b1;
			end
		end
	end

	assign cur_row = mem[cur_ndx];

	// In a normal cycle clears and sets both land in the live row
	assign upd_row = (cur_row & ~clr_mask) | set_mask;

	// In a copy cycle the issue clear is dropped while lane sets still go in
	assign copy_row = cur_row | set_mask;

	// ============================================================
	// Storage
	// ============================================================

	// After reset every register in every slot is ready
	always_ff @(posedge clka) begin
		if (rst) begin
			for (int r = 0; r < ready_pkg::NCHECK; r++) begin
				mem[r] <= '1;
			end
		end else if (copy_en) begin
			// Writebacks in the copy cycle reach both the old and the new row
			mem[copy_dst] <= copy_row;
			mem[cur_ndx] <= copy_row;
		end else begin
			mem[cur_ndx] <= upd_row;
		end
	end

	// ============================================================
	// Read ports
	// ============================================================

	// Reads see the row as it stood before this edge's writes
	always_comb begin
		rd_out[0] = cur_row[ctl.rd_a];
		rd_out[1] = cur_row[ctl.rd_b];
		// Zero register and the top register are hardwired ready
		if (ctl.rd_a == '0 || ctl.rd_a == LAST_PREG) begin
			rd_out[0] = 1'b1;
		end
		if (ctl.rd_b == '0 || ctl.rd_b == LAST_PREG) begin
			rd_out[1] = 1'b1;
		end
	end

	// An issue and a writeback to the same register in one cycle means the
	// rename stage and the writeback path disagree about that register
	for (genvar j = 1; j < NWP; j++) begin : g_lane_chk
		a_no_conflict: assert property (@(posedge clka) disable iff (rst)
			!(wr_en[0] && wr_en[j] && (wr_preg[0] == wr_preg[j])))
		else
			$error("checkpoint_valid_ram: issue and lane %0d fight over preg %0d",
				j - 1, wr_preg[0]);
	end

endmodule

`default_nettype wire

/* src/ready_result.sv */
`timescale 1ns/1ps
`default_nettype none

module ready_result (
	input logic clka,
	input logic rst,
	input ready_pkg::ram_ctl_t ctl,
	input logic [1:0] rd_out,
	input logic ckpt_err,
	output logic rsp_valid,
	output ready_pkg::query_rsp_t rsp
);

	// A query always answers, a checkpoint command only when refused
	logic fire;

	assign fire = ctl.query_en | ckpt_err;

	// Strobe for one cycle per answered command
	always_ff @(posedge clka) begin
		if (rst) begin
			rsp_valid <= 1'b0;
		end else begin
			rsp_valid <= fire;
		end
	end

	// Payload only changes when a response goes out
	always_ff @(posedge clka) begin
		if (fire) begin
			rsp.tag <= ctl.tag;
			// Ready bits are meaningful only for queries
			rsp.rdy_a <= rd_out[0] & ctl.query_en;
			rsp.rdy_b <= rd_out[1] & ctl.query_en;
			rsp.err <= ckpt_err;
		end
	end

	// One opcode per cycle, so an error can never share a slot with a query
	a_err_not_query: assert property (@(posedge clka) disable iff (rst)
		ckpt_err |-> !ctl.query_en)
	else
		$error("ready_result: checkpoint error raised during a query");

endmodule

`default_nettype wire

/* src/ready_track_top.sv */
`timescale 1ns/1ps
`default_nettype none

module ready_track_top #(
	parameter int NWB = 2
) (
	input logic clka,
	input logic rst,
	input logic cmd_valid,
	input ready_pkg::ready_cmd_t cmd,
	input ready_pkg::wb_lane_t wb [NWB],
	output logic rsp_valid,
	output ready_pkg::query_rsp_t rsp
);

	// ============================================================
	// Internal wiring
	// ============================================================

	// Registered controls and lanes from decode
	ready_pkg::ram_ctl_t ctl;
	ready_pkg::wb_lane_t wb_q [NWB];

	// Checkpoint stack state seen by the RAM
	ready_pkg::checkpt_ndx_t cur_ndx;
	logic copy_en;
	ready_pkg::checkpt_ndx_t copy_dst;

	// Inputs of the result stage
	logic ckpt_err;
	logic [1:0] rd_out;

	// ============================================================
	// Blocks
	// ============================================================

	// Decode stage, one cycle after the command strobe
	ready_cmd_decode #(
		.NWB(NWB)
	) u_decode (
		.clka(clka),
		.rst(rst),
		.cmd_valid(cmd_valid),
		.cmd(cmd),
		.wb(wb),
		.ctl(ctl),
		.wb_q(wb_q)
	);

	// Checkpoint stack pointer
	checkpoint_ctrl u_ckpt (
		.clka(clka),
		.rst(rst),
		.ctl(ctl),
		.cur_ndx(cur_ndx),
		.copy_en(copy_en),
		.copy_dst(copy_dst),
		.ckpt_err(ckpt_err)
	);

	// Valid bits, one row per checkpoint
	checkpoint_valid_ram #(
		.NWB(NWB)
	) u_ram (
		.clka(clka),
		.rst(rst),
		.cur_ndx(cur_ndx),
		.copy_en(copy_en),
		.copy_dst(copy_dst),
		.ctl(ctl),
		.wb_q(wb_q),
		.rd_out(rd_out)
	);

	// Response register, two cycles after the command
	ready_result u_result (
		.clka(clka),
		.rst(rst),
		.ctl(ctl),
		.rd_out(rd_out),
		.ckpt_err(ckpt_err),
		.rsp_valid(rsp_valid),
		.rsp(rsp)
	);

endmodule

`default_nettype wire

/* testbench/tb_ready_track.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_ready_track;

	localparam int NWB = 2;
	localparam ready_pkg::checkpt_ndx_t TOP_NDX =
		ready_pkg::checkpt_ndx_t'(ready_pkg::NCHECK - 1);
	localparam ready_pkg::pregno_t LAST_PREG =
		ready_pkg::pregno_t'(ready_pkg::PREGS - 1);

	logic clka;
	logic rst;
	logic cmd_valid;
	ready_pkg::ready_cmd_t cmd;
	ready_pkg::wb_lane_t wb [NWB];
	logic rsp_valid;
	ready_pkg::query_rsp_t rsp;

	// Stimulus for the next cycle, filled by the test tasks
	logic nxt_valid;
	ready_pkg::ready_cmd_t nxt_cmd;
	ready_pkg::wb_lane_t nxt_wb [NWB];

	// Reference model of the checkpoint rows and the stack depth
	logic [ready_pkg::PREGS-1:0] m_row [ready_pkg::NCHECK];
	ready_pkg::checkpt_ndx_t m_depth;

	// Stage 2 of the expected outputs lines up with the DUT two edges after the command
	logic ev [3];
	ready_pkg::query_rsp_t er [3];
	ready_pkg::checkpt_ndx_t ed [3];

	int err_cnt;
	int test_err;
	int n_pass;
	int n_fail;
	logic [3:0] tag_ctr;

	ready_track_top #(.NWB(NWB)) uut (
		.clka(clka),
		.rst(rst),
		.cmd_valid(cmd_valid),
		.cmd(cmd),
		.wb(wb),
		.rsp_valid(rsp_valid),
		.rsp(rsp)
	);

	always #2 clka = ~clka;

	// ============================================================
	// Checks against the model
	// ============================================================

	a_rsp_valid: assert property (@(posedge clka) disable iff (rst) rsp_valid == ev[2])
	else begin
		err_cnt++;
		$display("ERR rsp_valid expected %h got %h", ev[2], $sampled(rsp_valid));
	end

	a_rsp_data: assert property (@(posedge clka) disable iff (rst) ev[2] |-> rsp == er[2])
	else begin
		err_cnt++;
		$display("ERR rsp expected %h got %h", er[2], $sampled(rsp));
	end

	// Refused checkpoint commands must leave the stack pointer alone
	a_depth: assert property (@(posedge clka) disable iff (rst) uut.cur_ndx == ed[2])
	else begin
		err_cnt++;
		$display("ERR cur_ndx expected %h got %h", ed[2], $sampled(uut.cur_ndx));
	end

	// ============================================================
	// Model and drivers
	// ============================================================

	// Registers 0 and PREGS-1 are always ready
	function automatic logic predict_ready(input ready_pkg::pregno_t p);
		if (p == '0 || p == LAST_PREG) begin
			return 1'b1;
		end
		return m_row[m_depth][p];
	endfunction

	// Query reads the old row, then clears, sets, copy and restore apply in that order
	task automatic advance_model(output logic fire, output ready_pkg::query_rsp_t r);
		logic [ready_pkg::PREGS-1:0] sets;
		sets = '0;
		fire = 1'b0;
		r = '0;
		r.tag = nxt_cmd.tag;
		for (int i = 0; i < NWB; i++) begin
			if (nxt_wb[i].valid) begin
				sets[nxt_wb[i].preg] = 1'b1;
			end
		end
		if (nxt_valid && nxt_cmd.op == ready_pkg::OP_QUERY) begin
			fire = 1'b1;
			r.rdy_a = predict_ready(nxt_cmd.src_a);
			r.rdy_b = predict_ready(nxt_cmd.src_b);
		end
		if (nxt_valid && nxt_cmd.op == ready_pkg::OP_ISSUE) begin
			m_row[m_depth][nxt_cmd.dst] = 1'b0;
		end
		m_row[m_depth] = m_row[m_depth] | sets;
		if (nxt_valid && nxt_cmd.op == ready_pkg::OP_CKPT_NEW) begin
			if (m_depth == TOP_NDX) begin
				fire = 1'b1;
				r.err = 1'b1;
			end else begin
				m_row[m_depth + 1'b1] = m_row[m_depth];
				m_depth = m_depth + 1'b1;
			end
		end
		if (nxt_valid && nxt_cmd.op == ready_pkg::OP_CKPT_RESTORE) begin
			if (nxt_cmd.ckpt > m_depth) begin
				fire = 1'b1;
				r.err = 1'b1;
			end else begin
				m_depth = nxt_cmd.ckpt;
			end
		end
	endtask

	// Each call drives the prepared stimulus for one clock cycle and advances the model
	task automatic tick();
		logic fire;
		ready_pkg::query_rsp_t r;
		@(posedge clka);
		#1;
		cmd_valid = nxt_valid;
		cmd = nxt_cmd;
		for (int i = 0; i < NWB; i++) begin
			wb[i] = nxt_wb[i];
		end
		advance_model(fire, r);
		for (int s = 2; s > 0; s--) begin
			ev[s] = ev[s-1];
			er[s] = er[s-1];
			ed[s] = ed[s-1];
		end
		ev[0] = fire;
		er[0] = r;
		ed[0] = m_depth;
		nxt_valid = 1'b0;
		for (int i = 0; i < NWB; i++) begin
			nxt_wb[i] = '0;
		end
	endtask

	task automatic send(input ready_pkg::ready_op_e op, input int dst, input int a,
		input int b, input int ck);
		nxt_valid = 1'b1;
		nxt_cmd.op = op;
		nxt_cmd.dst = ready_pkg::pregno_t'(dst);
		nxt_cmd.src_a = ready_pkg::pregno_t'(a);
		nxt_cmd.src_b = ready_pkg::pregno_t'(b);
		nxt_cmd.ckpt = ready_pkg::checkpt_ndx_t'(ck);
		nxt_cmd.tag = tag_ctr;
		tag_ctr = tag_ctr + 4'd1;
		tick();
	endtask

	// A lane set with no command beside it
	task automatic writeback(input int lane, input int p);
		nxt_wb[lane].valid = 1'b1;
		nxt_wb[lane].preg = ready_pkg::pregno_t'(p);
		tick();
	endtask

	task automatic wait_rsp();
		int n;
		logic seen;
		n = 0;
		seen = 1'b0;
		while (!seen && n < 8) begin
			tick();
			seen = rsp_valid;
			n++;
		end
		if (!seen) begin
			err_cnt++;
			$display("timeout: no response strobe within 8 cycles at %0t", $time);
		end
	endtask

	task automatic query(input int a, input int b);
		send(ready_pkg::OP_QUERY, 0, a, b, 0);
		wait_rsp();
	endtask

	task automatic end_test(input string name);
		if (err_cnt == test_err) begin
			n_pass++;
			$display("test %s: ok", name);
		end else begin
			n_fail++;
			$display("test %s: %0d errors", name, err_cnt - test_err);
		end
		test_err = err_cnt;
	endtask

	// ============================================================
	// Test sequence
	// ============================================================

	initial begin
		#100000;
		$display("timeout: simulation did not finish");
		$display("=== FAIL ===");
		$finish;
	end

	initial begin
		void'($urandom(32'hf8d6e0f8));
		clka = 1'b0;
		rst = 1'b1;
		cmd_valid = 1'b0;
		cmd = '0;
		nxt_valid = 1'b0;
		nxt_cmd = '0;
		for (int i = 0; i < NWB; i++) begin
			wb[i] = '0;
			nxt_wb[i] = '0;
		end
		for (int r = 0; r < ready_pkg::NCHECK; r++) begin
			m_row[r] = '1;
		end
		m_depth = '0;
		for (int s = 0; s < 3; s++) begin
			ev[s] = 1'b0;
			er[s] = '0;
			ed[s] = '0;
		end
		err_cnt = 0;
		test_err = 0;
		n_pass = 0;
		n_fail = 0;
		tag_ctr = '0;
		repeat (3) tick();
		rst = 1'b0;

		// Idle cycles must stay silent, then every register reads ready
		repeat (5) tick();
		for (int i = 0; i < 8; i++) begin
			query(i * 7 + 1, 62 - i * 5);
		end
		end_test("reset_state");

		send(ready_pkg::OP_ISSUE, 10, 0, 0, 0);
		send(ready_pkg::OP_ISSUE, 20, 0, 0, 0);
		query(10, 20);
		writeback(0, 10);
		query(10, 20);
		writeback(1, 20);
		query(20, 10);
		end_test("issue_writeback");

		send(ready_pkg::OP_ISSUE, 0, 0, 0, 0);
		send(ready_pkg::OP_ISSUE, 63, 0, 0, 0);
		query(0, 63);
		end_test("fixed_ready");

		// Bits inside a checkpoint come back after the restore
		send(ready_pkg::OP_ISSUE, 5, 0, 0, 0);
		send(ready_pkg::OP_CKPT_NEW, 0, 0, 0, 0);
		send(ready_pkg::OP_ISSUE, 6, 0, 0, 0);
		send(ready_pkg::OP_ISSUE, 7, 0, 0, 0);
		writeback(0, 5);
		query(5, 6);
		send(ready_pkg::OP_CKPT_RESTORE, 0, 0, 0, 0);
		query(5, 6);
		query(7, 1);
		end_test("checkpoint_restore");

		repeat (ready_pkg::NCHECK - 1) send(ready_pkg::OP_CKPT_NEW, 0, 0, 0, 0);
		send(ready_pkg::OP_CKPT_NEW, 0, 0, 0, 0);
		wait_rsp();
		send(ready_pkg::OP_CKPT_RESTORE, 0, 0, 0, 3);
		send(ready_pkg::OP_CKPT_RESTORE, 0, 0, 0, 6);
		wait_rsp();
		query(5, 6);
		send(ready_pkg::OP_CKPT_RESTORE, 0, 0, 0, 0);
		end_test("checkpoint_refuse");

		// Queries get the largest share so that runs of back-to-back answers occur
		for (int n = 0; n < 2000; n++) begin
			nxt_valid = ($urandom_range(7, 0) != 0);
			case ($urandom_range(7, 0))
				0: nxt_cmd.op = ready_pkg::OP_NOP;
				1, 2: nxt_cmd.op = ready_pkg::OP_ISSUE;
				3, 4, 5: nxt_cmd.op = ready_pkg::OP_QUERY;
				6: nxt_cmd.op = ready_pkg::OP_CKPT_NEW;
				default: nxt_cmd.op = ready_pkg::OP_CKPT_RESTORE;
			endcase
			nxt_cmd.dst = ready_pkg::pregno_t'($urandom());
			nxt_cmd.src_a = ready_pkg::pregno_t'($urandom());
			nxt_cmd.src_b = ready_pkg::pregno_t'($urandom());
			nxt_cmd.ckpt = ready_pkg::checkpt_ndx_t'($urandom());
			nxt_cmd.tag = 4'($urandom());
			for (int i = 0; i < NWB; i++) begin
				nxt_wb[i].valid = ($urandom_range(1, 0) == 1);
				nxt_wb[i].preg = ready_pkg::pregno_t'($urandom());
				// An issue and a set of one register in one cycle is illegal input
				if (nxt_valid && nxt_cmd.op == ready_pkg::OP_ISSUE &&
					nxt_wb[i].preg == nxt_cmd.dst) begin
					nxt_wb[i].valid = 1'b0;
				end
			end
			tick();
		end
		repeat (4) tick();
		end_test("random_mix");

		$display("tests passed %0d, failed %0d, errors %0d", n_pass, n_fail, err_cnt);
		if (err_cnt == 0) begin
			$display("=== PASS ===");
		end else begin
			$display("=== FAIL ===");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* sim.f */
src/ready_pkg.sv
src/ready_cmd_decode.sv
src/checkpoint_ctrl.sv
src/checkpoint_valid_ram.sv
src/ready_result.sv
src/ready_track_top.sv
testbench/tb_ready_track.sv

/* Makefile */
LOG = sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator, run it and check the log"
	@echo "  clean  remove the build directory and the log"

test:
	verilator --binary --timing --assert --top-module tb_ready_track \
		--Mdir obj_dir -f sim.f
	./obj_dir/Vtb_ready_track > $(LOG) 2>&1; cat $(LOG)
	@grep -q "^=== PASS ===$$" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf obj_dir $(LOG)
